// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

    // Signed screen coordinate, leaves room for sprites partly off screen
    typedef logic signed [10:0] coord_t;

    // Signed per-tick velocity
    typedef logic signed [4:0]  delta_t;

    // End-of-game countdown value
    typedef logic [23:0]        timer_count_t;

    // Visible screen area
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // Sprite bounding box
    localparam int SPRITE_W = 8;
    localparam int SPRITE_H = 8;

    // Sprite engines and their indices
    localparam int N_SPRITES      = 2;
    localparam int SPRITE_TARGET  = 0;
    localparam int SPRITE_TORPEDO = 1;

endpackage

`default_nettype wire

// File: source/game_timebase.sv
`timescale 1ns/1ps
`default_nettype none

module game_timebase
#(
    parameter int UPDATE_PERIOD = 250_000,
    parameter int END_DELAY     = 10_000_000
)
(
    input  logic clk,
    input  logic reset,

    input  logic end_timer_start,

    output logic update_tick,
    output logic end_timer_running
);

    import game_pkg::*;

    localparam int DIV_W = $clog2(UPDATE_PERIOD + 1);

    logic [DIV_W-1:0] div_count;
    timer_count_t     end_count;

    // Free-running motion divider
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_count   <= '0;
            update_tick <= 1'b0;
        end
        else if (div_count == DIV_W'(UPDATE_PERIOD - 1))
        begin
            div_count   <= '0;
            update_tick <= 1'b1;
        end
        else
        begin
            div_count   <= div_count + 1'b1;
            update_tick <= 1'b0;
        end
    end

    // End-of-game countdown, restartable
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            end_count <= '0;
        else if (end_timer_start)
            end_count <= timer_count_t'(END_DELAY);
        else if (end_count != '0)
            end_count <= end_count - 1'b1;
    end

    assign end_timer_running = (end_count != '0);

endmodule

`default_nettype wire

// File: source/sprite_motion.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_motion
(
    input  logic             clk,
    input  logic             reset,

    input  logic             write_xy,
    input  logic             write_dxy,
    input  logic             enable_update,
    input  logic             update_tick,

    input  game_pkg::coord_t start_x,
    input  game_pkg::coord_t start_y,
    input  game_pkg::delta_t dx,
    input  game_pkg::delta_t dy,

    output game_pkg::coord_t x,
    output game_pkg::coord_t y,
    output logic             within_screen
);

    import game_pkg::*;

    delta_t dx_reg;
    delta_t dy_reg;

    // Velocity follows the inputs for as long as the strobe is held
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dx_reg <= '0;
            dy_reg <= '0;
        end
        else if (write_dxy)
        begin
            dx_reg <= dx;
            dy_reg <= dy;
        end
    end

    // A start position load wins over a motion step
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            x <= '0;
            y <= '0;
        end
        else if (write_xy)
        begin
            x <= start_x;
            y <= start_y;
        end
        else if (enable_update && update_tick)
        begin
            x <= x + coord_t'(dx_reg);
            y <= y + coord_t'(dy_reg);
        end
    end

    // Whole box inside the visible area, signed so negative means off screen
    assign within_screen = (x >= 0) && (x <= SCREEN_W - SPRITE_W)
                        && (y >= 0) && (y <= SCREEN_H - SPRITE_H);

endmodule

`default_nettype wire

// File: source/sprite_collision.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_collision
(
    input  logic             clk,
    input  logic             reset,

    input  game_pkg::coord_t target_x,
    input  game_pkg::coord_t target_y,
    input  game_pkg::coord_t torpedo_x,
    input  game_pkg::coord_t torpedo_y,

    output logic             collision
);

    import game_pkg::*;

    // One extra bit so the difference cannot wrap
    localparam int DIFF_W = $bits(coord_t) + 1;

    logic signed [DIFF_W-1:0] diff_x;
    logic signed [DIFF_W-1:0] diff_y;
    logic        [DIFF_W-1:0] abs_x;
    logic        [DIFF_W-1:0] abs_y;
    logic                     overlap;

    assign diff_x = DIFF_W'(target_x) - DIFF_W'(torpedo_x);
    assign diff_y = DIFF_W'(target_y) - DIFF_W'(torpedo_y);

    assign abs_x = (diff_x < 0) ? -diff_x : diff_x;
    assign abs_y = (diff_y < 0) ? -diff_y : diff_y;

    // Equal-size boxes overlap when both offsets are under the box size
    assign overlap = (abs_x < SPRITE_W) && (abs_y < SPRITE_H);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision <= 1'b0;
        else
            collision <= overlap;
    end

endmodule

`default_nettype wire

// File: source/game_master_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_master_fsm
(
    input  logic                           clk,
    input  logic                           reset,

    input  logic                           key,

    input  logic [game_pkg::N_SPRITES-1:0] within_screen,
    input  logic                           collision,
    input  logic                           end_timer_running,

    output logic [game_pkg::N_SPRITES-1:0] write_xy,
    output logic [game_pkg::N_SPRITES-1:0] write_dxy,
    output logic [game_pkg::N_SPRITES-1:0] enable_update,

    output logic                           end_timer_start,
    output logic                           game_won
);

    import game_pkg::*;

    // One-hot state bit positions
    localparam int ST_START_TARGET    = 0;
    localparam int ST_WAIT_KEY        = 1;
    localparam int ST_START_TORPEDO   = 2;
    localparam int ST_WAIT_COLLISION  = 3;
    localparam int ST_START_END_TIMER = 4;
    localparam int ST_WON             = 5;
    localparam int ST_LOST            = 6;
    localparam int N_STATES           = 7;

    logic [N_STATES-1:0] state;
    logic [N_STATES-1:0] next_state;

    logic end_of_game;
    logic collision_reg;

    // Round ends when anything leaves the screen or the sprites meet
    assign end_of_game = ~&within_screen | collision;

    // Second stage for the won/lost decision
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision_reg <= 1'b0;
        else
            collision_reg <= collision;
    end

    always_comb
    begin
        next_state = '0;

        if (state[ST_START_TARGET])
        begin
            next_state[ST_WAIT_KEY] = 1'b1;
        end
        else if (state[ST_WAIT_KEY])
        begin
            if (key)
                next_state[ST_START_TORPEDO] = 1'b1;
            else if (end_of_game)
                next_state[ST_START_END_TIMER] = 1'b1;
            else
                next_state[ST_WAIT_KEY] = 1'b1;
        end
        else if (state[ST_START_TORPEDO])
        begin
            next_state[ST_WAIT_COLLISION] = 1'b1;
        end
        else if (state[ST_WAIT_COLLISION])
        begin
            if (end_of_game)
                next_state[ST_START_END_TIMER] = 1'b1;
            else
                next_state[ST_WAIT_COLLISION] = 1'b1;
        end
        else if (state[ST_START_END_TIMER])
        begin
            if (collision_reg)
                next_state[ST_WON] = 1'b1;
            else
                next_state[ST_LOST] = 1'b1;
        end
        else if (state[ST_WON])
        begin
            if (end_timer_running)
                next_state[ST_WON] = 1'b1;
            else
                next_state[ST_START_TARGET] = 1'b1;
        end
        else if (state[ST_LOST])
        begin
            if (end_timer_running)
                next_state[ST_LOST] = 1'b1;
            else
                next_state[ST_START_TARGET] = 1'b1;
        end
        else
        begin
            // All-zero after reset, or a corrupted encoding
            next_state[ST_START_TARGET] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= '0;
        else
            state <= next_state;
    end

    // Both sprites take their start position at the top of a round
    assign write_xy[SPRITE_TARGET]  = state[ST_START_TARGET];
    assign write_xy[SPRITE_TORPEDO] = state[ST_START_TARGET];

    // Target velocity is fixed per round, torpedo steering stays live
    assign write_dxy[SPRITE_TARGET]  = state[ST_START_TARGET];
    assign write_dxy[SPRITE_TORPEDO] = state[ST_WAIT_KEY] | state[ST_WAIT_COLLISION];

    assign enable_update[SPRITE_TARGET]  = state[ST_WAIT_KEY] | state[ST_WAIT_COLLISION];
    assign enable_update[SPRITE_TORPEDO] = state[ST_WAIT_COLLISION];

    assign end_timer_start = state[ST_START_END_TIMER];
    assign game_won        = state[ST_WON];

endmodule

`default_nettype wire

// File: source/game_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_core_top
#(
    parameter int UPDATE_PERIOD = 250_000,
    parameter int END_DELAY     = 10_000_000
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             key,

    input  game_pkg::coord_t target_start_x,
    input  game_pkg::coord_t target_start_y,
    input  game_pkg::coord_t torpedo_start_x,
    input  game_pkg::coord_t torpedo_start_y,

    input  game_pkg::delta_t target_dx,
    input  game_pkg::delta_t target_dy,
    input  game_pkg::delta_t torpedo_dx,
    input  game_pkg::delta_t torpedo_dy,

    output game_pkg::coord_t target_x,
    output game_pkg::coord_t target_y,
    output game_pkg::coord_t torpedo_x,
    output game_pkg::coord_t torpedo_y,

    output logic             collision,
    output logic             game_won,
    output logic             game_over
);

    import game_pkg::*;

    logic [N_SPRITES-1:0] write_xy;
    logic [N_SPRITES-1:0] write_dxy;
    logic [N_SPRITES-1:0] enable_update;
    logic [N_SPRITES-1:0] within_screen;

    logic update_tick;
    logic end_timer_start;
    logic end_timer_running;

    // Per-sprite views indexed by sprite number
    coord_t start_x [N_SPRITES];
    coord_t start_y [N_SPRITES];
    delta_t vel_x   [N_SPRITES];
    delta_t vel_y   [N_SPRITES];
    coord_t pos_x   [N_SPRITES];
    coord_t pos_y   [N_SPRITES];

    assign start_x[SPRITE_TARGET]  = target_start_x;
    assign start_y[SPRITE_TARGET]  = target_start_y;
    assign vel_x[SPRITE_TARGET]    = target_dx;
    assign vel_y[SPRITE_TARGET]    = target_dy;

    assign start_x[SPRITE_TORPEDO] = torpedo_start_x;
    assign start_y[SPRITE_TORPEDO] = torpedo_start_y;
    assign vel_x[SPRITE_TORPEDO]   = torpedo_dx;
    assign vel_y[SPRITE_TORPEDO]   = torpedo_dy;

    assign target_x  = pos_x[SPRITE_TARGET];
    assign target_y  = pos_y[SPRITE_TARGET];
    assign torpedo_x = pos_x[SPRITE_TORPEDO];
    assign torpedo_y = pos_y[SPRITE_TORPEDO];

    assign game_over = end_timer_running;

    game_master_fsm u_master
    (
        .clk               (clk),
        .reset             (reset),
        .key               (key),
        .within_screen     (within_screen),
        .collision         (collision),
        .end_timer_running (end_timer_running),
        .write_xy          (write_xy),
        .write_dxy         (write_dxy),
        .enable_update     (enable_update),
        .end_timer_start   (end_timer_start),
        .game_won          (game_won)
    );

    for (genvar i = 0; i < N_SPRITES; i++)
    begin : g_sprite
        sprite_motion u_sprite
        (
            .clk           (clk),
            .reset         (reset),
            .write_xy      (write_xy[i]),
            .write_dxy     (write_dxy[i]),
            .enable_update (enable_update[i]),
            .update_tick   (update_tick),
            .start_x       (start_x[i]),
            .start_y       (start_y[i]),
            .dx            (vel_x[i]),
            .dy            (vel_y[i]),
            .x             (pos_x[i]),
            .y             (pos_y[i]),
            .within_screen (within_screen[i])
        );
    end

    sprite_collision u_collision
    (
        .clk       (clk),
        .reset     (reset),
        .target_x  (pos_x[SPRITE_TARGET]),
        .target_y  (pos_y[SPRITE_TARGET]),
        .torpedo_x (pos_x[SPRITE_TORPEDO]),
        .torpedo_y (pos_y[SPRITE_TORPEDO]),
        .collision (collision)
    );

    game_timebase
    #(
        .UPDATE_PERIOD (UPDATE_PERIOD),
        .END_DELAY     (END_DELAY)
    )
    u_timebase
    (
        .clk               (clk),
        .reset             (reset),
        .end_timer_start   (end_timer_start),
        .update_tick       (update_tick),
        .end_timer_running (end_timer_running)
    );

endmodule

`default_nettype wire

// File: dv/game_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_core_tb;

    import game_pkg::*;

    localparam int UPDATE_PERIOD = 4;
    localparam int END_DELAY     = 40;
    localparam int MAX_ROUNDS    = 32;
    localparam int STEER_LIMIT   = 6;

    logic   clk = 1'b0;
    logic   reset;
    logic   key;
    coord_t target_start_x, target_start_y, torpedo_start_x, torpedo_start_y;
    delta_t target_dx, target_dy, torpedo_dx, torpedo_dy;
    coord_t target_x, target_y, torpedo_x, torpedo_y;
    logic   collision;
    logic   game_won;
    logic   game_over;

    // Reference model of both sprites and their positions one cycle back
    coord_t model_tx, model_ty, model_px, model_py;
    coord_t prev_tx, prev_ty, prev_px, prev_py;
    bit     end_seen;
    bit     predicted_won;

    int     tests [MAX_ROUNDS][11];
    int     n_rounds = 0;
    integer seed = 68957;
    int     coord_errors = 0;
    int     flag_errors = 0;
    int     cycle_errors = 0;
    int     other_errors = 0;

    game_core_top
    #(
        .UPDATE_PERIOD (UPDATE_PERIOD),
        .END_DELAY     (END_DELAY)
    )
    u_dut
    (
        .clk             (clk),
        .reset           (reset),
        .key             (key),
        .target_start_x  (target_start_x),
        .target_start_y  (target_start_y),
        .torpedo_start_x (torpedo_start_x),
        .torpedo_start_y (torpedo_start_y),
        .target_dx       (target_dx),
        .target_dy       (target_dy),
        .torpedo_dx      (torpedo_dx),
        .torpedo_dy      (torpedo_dy),
        .target_x        (target_x),
        .target_y        (target_y),
        .torpedo_x       (torpedo_x),
        .torpedo_y       (torpedo_y),
        .collision       (collision),
        .game_won        (game_won),
        .game_over       (game_over)
    );

    always #50 clk = ~clk;

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp)
        begin
            coord_errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
        begin
            cycle_errors++;
            $display("ERR %s cycles got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic bit boxes_overlap(input coord_t ax, input coord_t ay,
                                         input coord_t bx, input coord_t by);
        int ddx;
        int ddy;
        ddx = int'(ax) - int'(bx);
        ddy = int'(ay) - int'(by);
        return (ddx < SPRITE_W) && (-ddx < SPRITE_W) && (ddy < SPRITE_H) && (-ddy < SPRITE_H);
    endfunction

    function automatic bit fits_screen(input coord_t x, input coord_t y);
        return (int'(x) >= 0) && (int'(x) <= SCREEN_W - SPRITE_W)
            && (int'(y) >= 0) && (int'(y) <= SCREEN_H - SPRITE_H);
    endfunction

    task automatic load_tests();
        int    fd;
        int    code;
        string line;
        fd = $fopen("dv/game_core_tests.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open the test data file");
            return;
        end
        while (!$feof(fd) && n_rounds < MAX_ROUNDS)
        begin
            code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d",
                           tests[n_rounds][0], tests[n_rounds][1], tests[n_rounds][2],
                           tests[n_rounds][3], tests[n_rounds][4], tests[n_rounds][5],
                           tests[n_rounds][6], tests[n_rounds][7], tests[n_rounds][8],
                           tests[n_rounds][9], tests[n_rounds][10]);
            // Comment lines match no number and are skipped whole
            if (code == 11)
                n_rounds++;
            else
                code = $fgets(line, fd);
        end
        $fclose(fd);
        if (n_rounds == 0)
        begin
            other_errors++;
            $display("No rounds were read from the test data file");
        end
    endtask

    task automatic drive_round(input int idx);
        target_start_x  = coord_t'(tests[idx][0]);
        target_start_y  = coord_t'(tests[idx][1]);
        target_dx       = delta_t'(tests[idx][2]);
        target_dy       = delta_t'(tests[idx][3]);
        torpedo_start_x = coord_t'(tests[idx][4]);
        torpedo_start_y = coord_t'(tests[idx][5]);
        torpedo_dx      = delta_t'(tests[idx][6]);
        torpedo_dy      = delta_t'(tests[idx][7]);
        key             = 1'b0;
    endtask

    // Random nudge of the torpedo's horizontal speed
    task automatic steer_torpedo(input int steer);
        int next_dx;
        next_dx = int'(torpedo_dx) + ($random(seed) % (steer + 1));
        if (next_dx > STEER_LIMIT)
            next_dx = STEER_LIMIT;
        if (next_dx < -STEER_LIMIT)
            next_dx = -STEER_LIMIT;
        torpedo_dx = delta_t'(next_dx);
    endtask

    // One clock of the model where a position change marks a motion tick
    task automatic observe_cycle(input bit torpedo_live, output bit stepped);
        bit exp_col;
        @(negedge clk);
        exp_col = boxes_overlap(prev_tx, prev_ty, prev_px, prev_py);
        stepped = (target_x !== model_tx) || (target_y !== model_ty);
        if (stepped)
        begin
            model_tx = coord_t'(int'(model_tx) + int'(target_dx));
            model_ty = coord_t'(int'(model_ty) + int'(target_dy));
            if (torpedo_live)
            begin
                model_px = coord_t'(int'(model_px) + int'(torpedo_dx));
                model_py = coord_t'(int'(model_py) + int'(torpedo_dy));
            end
        end
        check_coord("target_x", target_x, model_tx);
        check_coord("target_y", target_y, model_ty);
        check_coord("torpedo_x", torpedo_x, model_px);
        check_coord("torpedo_y", torpedo_y, model_py);
        check_flag("collision", collision, exp_col);
        if (!end_seen && (exp_col || !fits_screen(model_tx, model_ty)
                                  || !fits_screen(model_px, model_py)))
        begin
            end_seen      = 1'b1;
            predicted_won = exp_col;
        end
        prev_tx = model_tx;
        prev_ty = model_ty;
        prev_px = model_px;
        prev_py = model_py;
    endtask

    task automatic play_round(input int idx, output bit carried, output logic won);
        bit stepped;
        bit live;
        int steps;
        @(negedge clk);
        while (target_x !== target_start_x || target_y !== target_start_y
               || torpedo_x !== torpedo_start_x || torpedo_y !== torpedo_start_y)
            @(negedge clk);
        // Collision still reflects where the sprites were before the load
        carried = boxes_overlap(model_tx, model_ty, model_px, model_py);
        check_flag("collision", collision, carried);
        end_seen      = carried;
        predicted_won = carried;
        model_tx = target_start_x;
        model_ty = target_start_y;
        model_px = torpedo_start_x;
        model_py = torpedo_start_y;
        prev_tx = model_tx;
        prev_ty = model_ty;
        prev_px = model_px;
        prev_py = model_py;
        live  = 1'b0;
        steps = 0;
        do
        begin
            observe_cycle(live, stepped);
            if (!game_over && stepped)
            begin
                steps++;
                key = 1'b0;
                // Key right after a tick so the torpedo joins at the next one
                if (!live && !end_seen && steps == tests[idx][9])
                begin
                    key  = 1'b1;
                    live = 1'b1;
                end
                else if (live && tests[idx][8] > 0 && steps % 3 == 0)
                    steer_torpedo(tests[idx][8]);
            end
        end
        while (!game_over);
        won = game_won;
        check_flag("game_won", game_won, predicted_won);
        if (!end_seen)
        begin
            other_errors++;
            $display("Round %0d ended although the model saw no end of game", idx);
        end
    endtask

    task automatic measure_end_delay();
        int cycles;
        cycles = 1;
        @(negedge clk);
        while (game_over)
        begin
            cycles++;
            @(negedge clk);
        end
        check_cycles("game_over", cycles, END_DELAY);
    endtask

    initial
    begin
        bit   carried;
        logic won;
        reset = 1'b1;
        model_tx = '0;
        model_ty = '0;
        model_px = '0;
        model_py = '0;
        load_tests();
        drive_round(0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("game_won", game_won, 1'b0);
        check_flag("game_over", game_over, 1'b0);
        for (int i = 0; i < n_rounds; i++)
        begin
            drive_round(i);
            play_round(i, carried, won);
            measure_end_delay();
            // Sprites left overlapping end the next round at once and it is played again
            if (carried)
            begin
                play_round(i, carried, won);
                measure_end_delay();
            end
            check_flag("game_won", won, tests[i][10] != 0);
        end
        $display("Errors: coord %0d, flag %0d, cycles %0d, other %0d",
                 coord_errors, flag_errors, cycle_errors, other_errors);
        if (coord_errors + flag_errors + cycle_errors + other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog sized from the number of rounds in the data file
    initial
    begin
        wait (n_rounds > 0);
        repeat (n_rounds * (END_DELAY + 700 * UPDATE_PERIOD + 100)) @(posedge clk);
        $display("The run timed out before all rounds were played");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: game_core.f
source/game_pkg.sv
source/game_timebase.sv
source/sprite_motion.sv
source/sprite_collision.sv
source/game_master_fsm.sv
source/game_core_top.sv
dv/game_core_tb.sv

// File: dv/game_core_tests.txt
# target_x target_y target_dx target_dy torpedo_x torpedo_y torpedo_dx torpedo_dy
# steer_step key_ticks expect_won   (decimal, one round per line)
100 100  4  0 300 400  0 -12 0  25 1
 50 400  3  0 320 300  0 -10 1   5 0
600 200  8  0 300 400  0  -5 0  50 0
400  60 -5  0 200 460 -2  -8 0  10 1
300  50  2  1  20 300 -1   0 0   3 0
100 440  0  7 500 100  0   0 0  20 0
 10 240  6  0 310 240  0   0 0 100 1
